//--- logic/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // word width and register count come from the ISA
  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]             word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
  typedef logic [6:0]                  opcode_t;
  typedef logic [2:0]                  funct3_t;
  typedef logic [2:0]                  op_class_t;

  // major opcodes of the kept subset
  localparam opcode_t OP_IMM    = 7'b001_0011;
  localparam opcode_t OP_LUI    = 7'b011_0111;
  localparam opcode_t OP_AUIPC  = 7'b001_0111;
  localparam opcode_t OP_JAL    = 7'b110_1111;
  localparam opcode_t OP_JALR   = 7'b110_0111;
  localparam opcode_t OP_LOAD   = 7'b000_0011;
  localparam opcode_t OP_STORE  = 7'b010_0011;
  localparam opcode_t OP_SYSTEM = 7'b111_0011;

  // funct3 values that select addi, jalr, lw and sw
  localparam funct3_t F3_ADDI = 3'b000;
  localparam funct3_t F3_JALR = 3'b000;
  localparam funct3_t F3_WORD = 3'b010;

  // instruction classes seen by execute and control
  localparam op_class_t CLS_ALU   = 3'd0;
  localparam op_class_t CLS_JAL   = 3'd1;
  localparam op_class_t CLS_JALR  = 3'd2;
  localparam op_class_t CLS_LOAD  = 3'd3;
  localparam op_class_t CLS_STORE = 3'd4;
  localparam op_class_t CLS_HALT  = 3'd5;
  localparam op_class_t CLS_NOP   = 3'd6;

  // addi x0, x0, 0
  localparam word_t NOP_INST         = 32'h0000_0013;
  localparam word_t EBREAK_INST      = 32'h0010_0073;
  localparam word_t RESET_PC_DEFAULT = 32'h8000_0000;

  typedef struct packed {
    op_class_t cls;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    // adder operand a is pc
    logic      a_is_pc;
    // adder operand a is zero, for lui
    logic      a_is_zero;
  } decoded_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  we;
  } dmem_req_t;

  typedef enum logic [2:0] {
    EXEC,
    MEM_REQ,
    MEM_RELEASE,
    COMMIT,
    HALTED
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- logic/core_control.sv
`timescale 1ns/1ps
`default_nettype none

module core_control import rv_core_pkg::*; #(
  parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
  input  logic      clk,
  input  logic      rst,
  input  decoded_t  dec,
  input  word_t     mem_addr,
  input  word_t     store_data,
  input  word_t     next_pc,
  output word_t     pc,
  output logic      rf_we,
  output word_t     load_data,
  output dmem_req_t dmem_req,
  output logic      req,
  input  logic      ack,
  input  word_t     dmem_rdata,
  output logic      halt
);

  ctrl_state_e state;
  logic        is_mem;
  logic        writes_rd;
  logic        start_mem;
  logic        mem_done;
  logic        commit;

  assign is_mem    = (dec.cls == CLS_LOAD) || (dec.cls == CLS_STORE);
  assign writes_rd = (dec.cls == CLS_ALU) || (dec.cls == CLS_JAL) ||
                     (dec.cls == CLS_JALR) || (dec.cls == CLS_LOAD);

  // new request only once the previous ack has dropped
  assign start_mem = (state == EXEC) && is_mem && !ack;
  assign mem_done  = (state == MEM_REQ) && ack;

  // single-cycle classes commit out of EXEC, loads and stores out of COMMIT
  assign commit = ((state == EXEC) && !is_mem && (dec.cls != CLS_HALT)) ||
                  (state == COMMIT);

  // write lands on the commit edge, never to x0 and never in reset
  assign rf_we = !rst && commit && writes_rd && (dec.rd != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= EXEC;
      pc    <= RESET_PC;
      req   <= 1'b0;
      halt  <= 1'b0;
    end else begin
      if (commit) begin
        pc <= next_pc;
      end
      case (state)
        EXEC: begin
          if (dec.cls == CLS_HALT) begin
            state <= HALTED;
          end else if (start_mem) begin
            state <= MEM_REQ;
            req   <= 1'b1;
          end
        end
        // hold req through back-pressure
        MEM_REQ: begin
          if (ack) begin
            state <= MEM_RELEASE;
            req   <= 1'b0;
          end
        end
        // wait for memory to drop ack
        MEM_RELEASE: begin
          if (!ack) begin
            state <= COMMIT;
          end
        end
        COMMIT: begin
          state <= EXEC;
        end
        // sticky until reset
        HALTED: begin
          halt <= 1'b1;
        end
        default: begin
          state <= EXEC;
        end
      endcase
    end
  end

  // request payload stays stable while req is up
  always_ff @(posedge clk) begin
    if (start_mem) begin
      dmem_req.addr  <= mem_addr;
      dmem_req.wdata <= store_data;
      dmem_req.we    <= (dec.cls == CLS_STORE);
    end
    // rdata only valid while ack is high
    if (mem_done) begin
      load_data <= dmem_rdata;
    end
  end

endmodule

`default_nettype wire

//--- logic/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode import rv_core_pkg::*; (
  input  word_t    inst,
  output decoded_t dec
);

  opcode_t opcode;
  funct3_t funct3;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_j;
  word_t   imm_u;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // sign-extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  // upper immediate already in place
  assign imm_u = {inst[31:12], 12'h000};

  always_comb begin
    dec           = '0;
    dec.rs1       = inst[19:15];
    dec.rs2       = inst[24:20];
    dec.rd        = inst[11:7];
    dec.cls       = CLS_NOP;
    dec.imm       = imm_i;
    case (opcode)
      OP_IMM: begin
        // only addi, the other op-imm forms fall through as nop
        if (funct3 == F3_ADDI) begin
          dec.cls = CLS_ALU;
        end
      end
      OP_LUI: begin
        dec.cls       = CLS_ALU;
        dec.imm       = imm_u;
        dec.a_is_zero = 1'b1;
      end
      OP_AUIPC: begin
        dec.cls     = CLS_ALU;
        dec.imm     = imm_u;
        dec.a_is_pc = 1'b1;
      end
      OP_JAL: begin
        dec.cls     = CLS_JAL;
        dec.imm     = imm_j;
        dec.a_is_pc = 1'b1;
      end
      OP_JALR: begin
        if (funct3 == F3_JALR) begin
          dec.cls = CLS_JALR;
        end
      end
      // word accesses only
      OP_LOAD: begin
        if (funct3 == F3_WORD) begin
          dec.cls = CLS_LOAD;
        end
      end
      OP_STORE: begin
        if (funct3 == F3_WORD) begin
          dec.cls = CLS_STORE;
          dec.imm = imm_s;
        end
      end
      OP_SYSTEM: begin
        if (inst == EBREAK_INST) begin
          dec.cls = CLS_HALT;
        end
      end
      default: begin
        dec.cls = CLS_NOP;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
  input  logic      clk,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t rd_addr,
  input  logic      we,
  input  word_t     wdata,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  // x1..x31, x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (we && (rd_addr != '0)) begin
      regs[rd_addr] <= wdata;
    end
  end

  // combinational reads, x0 reads zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- logic/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_core_pkg::*; (
  input  decoded_t dec,
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    load_data,
  output word_t    sum,
  output word_t    store_data,
  output word_t    next_pc,
  output word_t    wb_data
);

  word_t op_a;
  word_t pc_plus4;

  // operand a is pc, zero or rs1
  always_comb begin
    if (dec.a_is_pc) begin
      op_a = pc;
    end else if (dec.a_is_zero) begin
      op_a = '0;
    end else begin
      op_a = rs1_data;
    end
  end

  // one adder for alu results, jump targets and addresses
  assign sum      = op_a + dec.imm;
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (dec.cls)
      CLS_JAL:  next_pc = sum;
      // jalr target has bit 0 cleared
      CLS_JALR: next_pc = {sum[XLEN-1:1], 1'b0};
      default:  next_pc = pc_plus4;
    endcase
  end

  // link value for jumps
  always_comb begin
    case (dec.cls)
      CLS_JAL,
      CLS_JALR: wb_data = pc_plus4;
      CLS_LOAD: wb_data = load_data;
      default:  wb_data = sum;
    endcase
  end

  assign store_data = rs2_data;

endmodule

`default_nettype wire

//--- logic/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; #(
  parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
  input  logic      clk,
  input  logic      rst,
  input  word_t     inst,
  output word_t     pc,
  output dmem_req_t dmem_req,
  output logic      req,
  input  logic      ack,
  input  word_t     dmem_rdata,
  output logic      halt
);

  // decoded view of the current instruction
  decoded_t dec;

  // register file read ports
  word_t rs1_data;
  word_t rs2_data;

  // execute results
  word_t sum;
  word_t store_data;
  word_t next_pc;
  word_t wb_data;

  // from control
  word_t load_data;
  logic  rf_we;

  // pc, handshake and commit sequencing
  core_control #(
    .RESET_PC (RESET_PC)
  ) core_control_inst (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec),
    .mem_addr   (sum),
    .store_data (store_data),
    .next_pc    (next_pc),
    .pc         (pc),
    .rf_we      (rf_we),
    .load_data  (load_data),
    .dmem_req   (dmem_req),
    .req        (req),
    .ack        (ack),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  inst_decode inst_decode_inst (
    .inst (inst),
    .dec  (dec)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .rs1_addr (dec.rs1),
    .rs2_addr (dec.rs2),
    .rd_addr  (dec.rd),
    .we       (rf_we),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // sum doubles as the load/store address
  exec_unit exec_unit_inst (
    .dec        (dec),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .load_data  (load_data),
    .sum        (sum),
    .store_data (store_data),
    .next_pc    (next_pc),
    .wb_data    (wb_data)
  );

endmodule

`default_nettype wire

//--- tb/rv_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_props import rv_core_pkg::*; (
  input logic      clk,
  input logic      rst,
  input word_t     pc,
  input dmem_req_t dmem_req,
  input logic      req,
  input logic      ack,
  input logic      halt
);

  // request and payload held until ack
  req_held: assert property (
    @(posedge clk) disable iff (rst)
    (req && !ack) |=> (req && $stable(dmem_req))
  ) else $error("req dropped or payload changed before ack");

  // no new request while previous ack still high
  req_after_ack: assert property (
    @(posedge clk) disable iff (rst)
    (!req && ack) |=> !req
  ) else $error("req rose while ack was high");

  // halt is sticky
  halt_sticky: assert property (
    @(posedge clk) disable iff (rst)
    halt |=> halt
  ) else $error("halt fell outside reset");

  // pc frozen once halted
  pc_frozen: assert property (
    @(posedge clk) disable iff (rst)
    halt |=> $stable(pc)
  ) else $error("pc changed while halted");

endmodule

bind rv_core_top rv_core_props rv_core_props_inst (
  .clk      (clk),
  .rst      (rst),
  .pc       (pc),
  .dmem_req (dmem_req),
  .req      (req),
  .ack      (ack),
  .halt     (halt)
);

`default_nettype wire

//--- tb/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

  localparam int CLK_NS       = 8;
  localparam int RESET_CYCLES = 8;
  localparam int HOLD_CYCLES  = 20;
  localparam int PROG_LEN     = 27;
  localparam int ROM_DEPTH    = 32;

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  word_t     inst;
  word_t     pc;
  dmem_req_t dmem_req;
  logic      req;
  logic      ack = 1'b0;
  word_t     dmem_rdata = '0;
  logic      halt;

  // program rom and the pc expected after each entry
  word_t prog_inst [ROM_DEPTH];
  word_t prog_next [ROM_DEPTH];
  int    prog_count = 0;
  word_t rom_off;

  // expected stores, in program order
  word_t exp_addr [16];
  word_t exp_data [16];
  string exp_name [16];
  int    store_count = 0;
  int    store_idx = 0;

  word_t data_mem [word_t];
  int    ack_delay = 0;
  logic  delay_armed = 1'b0;
  word_t last_pc;
  word_t halt_pc;
  int    mismatches = 0;
  int    others = 0;

  rv_core_top #(
    .RESET_PC (RESET_PC_DEFAULT)
  ) rv_core_top_inst (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .pc         (pc),
    .dmem_req   (dmem_req),
    .req        (req),
    .ack        (ack),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // rv32i encodings
  function automatic word_t itype(input logic [11:0] imm, input reg_addr_t rs1,
                                  input funct3_t f3, input reg_addr_t rd, input opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t stype(input logic [11:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t utype(input logic [19:0] imm, input reg_addr_t rd,
                                  input opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic word_t jtype(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // unwritten words follow the whole address
  function automatic word_t read_word(input word_t addr);
    return data_mem.exists(addr) ? data_mem[addr] : (addr ^ 32'h5a5a_a5a5);
  endfunction

  task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    mismatches++;
    $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
  endtask

  task automatic report_failure(input string msg);
    others++;
    $display("ERROR: %s", msg);
  endtask

  // next_off is relative to the reset pc, zero where the entry is skipped
  task automatic append_inst(input word_t w, input word_t next_off);
    prog_inst[prog_count] = w;
    prog_next[prog_count] = RESET_PC_DEFAULT + next_off;
    prog_count++;
  endtask

  task automatic append_store(input word_t addr, input word_t data, input string name);
    exp_addr[store_count] = addr;
    exp_data[store_count] = data;
    exp_name[store_count] = name;
    store_count++;
  endtask

  task automatic load_program();
    for (int i = 0; i < ROM_DEPTH; i++) begin
      prog_inst[i] = NOP_INST;
      prog_next[i] = '0;
    end
    append_inst(itype(12'h123, 5'd0, F3_ADDI, 5'd1, OP_IMM), 32'h04);
    append_inst(utype(20'h12345, 5'd2, OP_LUI), 32'h08);
    append_inst(utype(20'h00001, 5'd3, OP_AUIPC), 32'h0c);
    append_inst(itype(12'h100, 5'd0, F3_ADDI, 5'd5, OP_IMM), 32'h10);
    append_inst(stype(12'h000, 5'd1, 5'd5), 32'h14);
    append_inst(stype(12'h004, 5'd2, 5'd5), 32'h18);
    append_inst(stype(12'h008, 5'd3, 5'd5), 32'h1c);
    append_inst(itype(12'hffd, 5'd1, F3_ADDI, 5'd4, OP_IMM), 32'h20);
    append_inst(stype(12'h00c, 5'd4, 5'd5), 32'h24);
    // jal over one stray store
    append_inst(jtype(21'd8, 5'd6), 32'h2c);
    append_inst(stype(12'h07c, 5'd1, 5'd0), 32'h00);
    append_inst(stype(12'h010, 5'd6, 5'd5), 32'h30);
    append_inst(utype(20'h80000, 5'd8, OP_LUI), 32'h34);
    // odd jalr target, lands on 0x44
    append_inst(itype(12'h045, 5'd8, F3_JALR, 5'd9, OP_JALR), 32'h44);
    append_inst(stype(12'h07c, 5'd1, 5'd0), 32'h00);
    append_inst(NOP_INST, 32'h00);
    append_inst(NOP_INST, 32'h00);
    append_inst(stype(12'h014, 5'd9, 5'd5), 32'h48);
    append_inst(itype(12'h200, 5'd0, F3_WORD, 5'd10, OP_LOAD), 32'h4c);
    append_inst(stype(12'h018, 5'd10, 5'd5), 32'h50);
    append_inst(itype(12'h055, 5'd0, F3_ADDI, 5'd0, OP_IMM), 32'h54);
    append_inst(stype(12'h01c, 5'd0, 5'd5), 32'h58);
    append_inst(stype(12'h300, 5'd5, 5'd0), 32'h5c);
    append_inst(NOP_INST, 32'h60);
    // add x3, x1, x2 is outside the subset
    append_inst(32'h0020_81b3, 32'h64);
    append_inst(stype(12'h020, 5'd3, 5'd5), 32'h68);
    append_inst(EBREAK_INST, 32'h68);
  endtask

  task automatic load_stores();
    append_store(32'h100, 32'h123, "addi");
    append_store(32'h104, 32'h1234_5000, "lui");
    append_store(32'h108, RESET_PC_DEFAULT + 32'h8 + 32'h1000, "auipc");
    append_store(32'h10c, 32'h123 - 32'h3, "addi_neg");
    append_store(32'h110, RESET_PC_DEFAULT + 32'h24 + 32'h4, "jal_link");
    append_store(32'h114, RESET_PC_DEFAULT + 32'h34 + 32'h4, "jalr_link");
    append_store(32'h118, 32'hcafe_f00d, "lw_sw");
    append_store(32'h11c, 32'h0, "x0_write");
    append_store(32'h300, 32'h100, "x0_base");
    append_store(32'h120, RESET_PC_DEFAULT + 32'h8 + 32'h1000, "rtype_nop");
    data_mem[32'h200] = 32'hcafe_f00d;
  endtask

  task automatic check_store(input word_t addr, input word_t data);
    assert (store_idx < store_count)
      else report_failure($sformatf("unexpected store of %h to %h", data, addr));
    if (store_idx < store_count) begin
      assert (addr == exp_addr[store_idx])
        else report_mismatch({exp_name[store_idx], " addr"}, exp_addr[store_idx], addr);
      assert (data == exp_data[store_idx])
        else report_mismatch({exp_name[store_idx], " data"}, exp_data[store_idx], data);
    end
    store_idx++;
  endtask

  task automatic check_next_pc(input word_t from, input word_t to);
    word_t off;
    off = from - RESET_PC_DEFAULT;
    assert (off < 32'd128)
      else report_failure($sformatf("pc left the program from %h", from));
    if (off < 32'd128) begin
      assert (to == prog_next[off[6:2]])
        else report_mismatch($sformatf("next_pc after %h", from), prog_next[off[6:2]], to);
    end
  endtask

  // combinational fetch, nop outside the table
  assign rom_off = pc - RESET_PC_DEFAULT;
  always_comb begin
    if ((rom_off < 32'd128) && (rom_off[1:0] == 2'b00)) begin
      inst = prog_inst[rom_off[6:2]];
    end else begin
      inst = NOP_INST;
    end
  end

  // data memory, random 0..3 cycle delay on ack rise and on ack release
  always @(posedge clk) begin
    if (rst) begin
      ack         <= 1'b0;
      delay_armed = 1'b0;
    end else if (req && !ack) begin
      if (!delay_armed) begin
        delay_armed = 1'b1;
        ack_delay   = $urandom % 4;
      end
      if (ack_delay == 0) begin
        ack         <= 1'b1;
        delay_armed = 1'b0;
        if (dmem_req.we) begin
          data_mem[dmem_req.addr] = dmem_req.wdata;
          check_store(dmem_req.addr, dmem_req.wdata);
        end else begin
          dmem_rdata <= read_word(dmem_req.addr);
        end
      end else begin
        ack_delay--;
      end
    end else if (ack && !req) begin
      // ack lingers after req falls
      if (!delay_armed) begin
        delay_armed = 1'b1;
        ack_delay   = $urandom % 4;
      end
      if (ack_delay == 0) begin
        ack         <= 1'b0;
        delay_armed = 1'b0;
      end else begin
        ack_delay--;
      end
    end
  end

  // every pc step against the table
  always @(negedge clk) begin
    if (rst) begin
      last_pc = RESET_PC_DEFAULT;
    end else if (pc != last_pc) begin
      check_next_pc(last_pc, pc);
      last_pc = pc;
    end
  end

  initial begin
    #(PROG_LEN * 10 * CLK_NS);
    $display("ERROR: watchdog expired, core never halted or stalled in a handshake");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    void'($urandom(14));
    load_program();
    load_stores();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (pc == RESET_PC_DEFAULT) else report_mismatch("reset_pc", RESET_PC_DEFAULT, pc);
    while (!halt) @(negedge clk);
    halt_pc = pc;
    assert (halt_pc == RESET_PC_DEFAULT + 32'h68)
      else report_mismatch("ebreak_pc", RESET_PC_DEFAULT + 32'h68, halt_pc);
    // frozen after halt
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      assert (pc == halt_pc) else report_mismatch("halted_pc", halt_pc, pc);
      assert (!req) else report_failure("req raised after halt");
      assert (halt) else report_failure("halt dropped after ebreak");
    end
    assert (store_idx == store_count)
      else report_failure($sformatf("saw %0d of %0d stores", store_idx, store_count));
    $display("errors: %0d mismatches, %0d other", mismatches, others);
    if ((mismatches + others) == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
logic/rv_core_pkg.sv
logic/core_control.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/rv_core_top.sv
tb/rv_core_props.sv
tb/rv_core_tb.sv

//--- Makefile
# Verilator build and run of the core testbench

VERILATOR  ?= verilator
TOP        ?= rv_core_tb
RTL_TOP    ?= rv_core_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG   ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status follows the search for the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
